//--- chanlink_pkg.sv
`default_nettype none

package chanlink_pkg;

	////////////////////////////////
	// Widths
	////////////////////////////////
	localparam int SMP_W     = 12;
	localparam int CRC_W     = 15;
	localparam int CRC_IN_W  = 13;	// Sample plus zero pad bit
	localparam int L1A_W     = 24;
	localparam int WORD_W    = 16;
	localparam int SEQ_W     = 7;
	localparam int OCC_W     = 5;
	localparam int TRL_SLOTS = 4;

	typedef struct packed {
		logic             mlt_ovlp;
		logic             ovlp;
		logic [SMP_W-1:0] smp;
	} evt_word_t;

	typedef struct packed {
		logic [L1A_W-1:0] l1a_num;
	} l1a_rec_t;

	typedef logic [WORD_W-1:0] frame_word_t;

	localparam frame_word_t TRL_MARKER = 16'h700C;
	localparam frame_word_t TRL_FILL   = 16'h7FFF;
	localparam logic [3:0]  TRL_TAG    = 4'h7;

	// One step of the 15-bit frame CRC, 13 input bits per step
	function automatic logic [CRC_W-1:0] crc15_d13(input logic [CRC_IN_W-1:0] d,
		input logic [CRC_W-1:0] c);
		logic [CRC_W-1:0] n;
		n[0] = d[0] ^ c[2];
		for (int i = 1; i < CRC_IN_W; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];	// Regular middle taps
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

`default_nettype wire

//--- chanlink_readout.sv
`timescale 1ns/1ns
`default_nettype none

module chanlink_readout import chanlink_pkg::*; #(
	parameter int NUM_SAMPLES = 16,
	parameter int FIFO_DEPTH  = 16
)(
	input  wire         RCLK,
	input  wire         RST_RESYNC,
	input  wire         evt_wr_i,
	input  wire evt_word_t evt_i,
	input  wire         l1a_wr_i,
	input  wire l1a_rec_t  l1a_i,
	input  wire         warn_i,
	output frame_word_t dout_o,
	output logic        dvalid_o,
	output logic        last_wrd_o,
	output logic        mlt_ovlp_o
);

	evt_word_t        evt_head;
	l1a_rec_t         l1a_head;
	logic             evt_empty;
	logic             l1a_empty;
	logic [OCC_W-1:0] l1a_count;
	logic             seq_rd;
	logic             seq_trl;
	logic [1:0]       seq_slot;
	logic             seq_clr;
	logic             seq_last;
	frame_word_t      lane_word  [3];
	logic             lane_valid [3];
	logic             lane_last  [3];
	logic             lane_mlt   [3];

	////////////////////////////////
	// Input FIFOs
	////////////////////////////////
	sync_fifo #(.payload_t(evt_word_t), .FIFO_DEPTH(FIFO_DEPTH)) u_evt_fifo (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.wr_i(evt_wr_i), .wr_data_i(evt_i),
		.rd_i(seq_rd), .rd_data_o(evt_head),
		.empty_o(evt_empty), .full_o(), .count_o()
	);

	sync_fifo #(.payload_t(l1a_rec_t), .FIFO_DEPTH(FIFO_DEPTH)) u_l1a_fifo (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.wr_i(l1a_wr_i), .wr_data_i(l1a_i),
		.rd_i(seq_last), .rd_data_o(l1a_head),	// Pop at trailer slot 3
		.empty_o(l1a_empty), .full_o(), .count_o(l1a_count)
	);

	frame_sequencer #(.NUM_SAMPLES(NUM_SAMPLES)) u_seq (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.l1a_empty_i(l1a_empty), .evt_empty_i(evt_empty),
		.rd_o(seq_rd), .trl_o(seq_trl), .slot_o(seq_slot),
		.clr_o(seq_clr), .last_o(seq_last)
	);

	////////////////////////////////
	// Redundant frame lanes
	////////////////////////////////
	for (genvar i = 0; i < 3; i++) begin : g_lane
		frame_lane u_lane (
			.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
			.rd_i(seq_rd), .trl_i(seq_trl), .slot_i(seq_slot),
			.clr_i(seq_clr), .last_i(seq_last),
			.evt_i(evt_head), .l1a_i(l1a_head), .occ_i(l1a_count), .warn_i(warn_i),
			.word_o(lane_word[i]), .valid_o(lane_valid[i]),
			.last_o(lane_last[i]), .mlt_ovlp_o(lane_mlt[i])
		);
	end

	lane_voter u_voter (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.word_a_i(lane_word[0]), .word_b_i(lane_word[1]), .word_c_i(lane_word[2]),
		.valid_a_i(lane_valid[0]), .valid_b_i(lane_valid[1]), .valid_c_i(lane_valid[2]),
		.last_a_i(lane_last[0]), .last_b_i(lane_last[1]), .last_c_i(lane_last[2]),
		.mlt_a_i(lane_mlt[0]), .mlt_b_i(lane_mlt[1]), .mlt_c_i(lane_mlt[2]),
		.dout_o(dout_o), .dvalid_o(dvalid_o),
		.last_wrd_o(last_wrd_o), .mlt_ovlp_o(mlt_ovlp_o)
	);

endmodule

`default_nettype wire

//--- frame_lane.sv
`timescale 1ns/1ns
`default_nettype none

module frame_lane import chanlink_pkg::*; (
	input  wire              RCLK,
	input  wire              RST_RESYNC,
	input  wire              rd_i,
	input  wire              trl_i,
	input  wire [1:0]        slot_i,
	input  wire              clr_i,
	input  wire              last_i,
	input  wire evt_word_t   evt_i,
	input  wire l1a_rec_t    l1a_i,
	input  wire [OCC_W-1:0]  occ_i,
	input  wire              warn_i,
	output frame_word_t      word_o,
	output logic             valid_o,
	output logic             last_o,
	output logic             mlt_ovlp_o
);

	logic [CRC_W-1:0]    crc_q;
	logic [CRC_IN_W-1:0] crc_din;
	frame_word_t         data_word;
	frame_word_t         trl_word;
	frame_word_t         word_q;
	logic                valid_q;
	logic                last_q;
	logic                mlt_q;

	assign crc_din   = CRC_IN_W'(evt_i.smp);	// Zero on top
	assign data_word = {1'b0, ~evt_i.ovlp, 2'b00, evt_i.smp};

	////////////////////////////////
	// Trailer mux
	////////////////////////////////
	always_comb begin
		case (slot_i)
			2'd0:    trl_word = {1'b0, crc_q};
			2'd1:    trl_word = TRL_MARKER;
			2'd2:    trl_word = {TRL_TAG, l1a_i.l1a_num[5:0], occ_i, warn_i};
			default: trl_word = TRL_FILL;
		endcase
	end

	// Clear wins over accumulation
	always_ff @(posedge RCLK) begin
		if (clr_i) begin
			crc_q <= '0;
		end else if (rd_i) begin
			crc_q <= crc15_d13(crc_din, crc_q);
		end
	end

	always_ff @(posedge RCLK) begin
		if (rd_i) begin
			word_q <= data_word;
		end else if (trl_i) begin
			word_q <= trl_word;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid_q <= 1'b0;
			last_q  <= 1'b0;
			mlt_q   <= 1'b0;
		end else begin
			valid_q <= rd_i || trl_i;
			last_q  <= last_i;
			mlt_q   <= rd_i && evt_i.mlt_ovlp;	// Low in trailer slots
		end
	end

	assign word_o     = word_q;
	assign valid_o    = valid_q;
	assign last_o     = last_q;
	assign mlt_ovlp_o = mlt_q;

endmodule

`default_nettype wire

//--- frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_sequencer import chanlink_pkg::*; #(
	parameter int NUM_SAMPLES = 16
)(
	input  wire        RCLK,
	input  wire        RST_RESYNC,
	input  wire        l1a_empty_i,
	input  wire        evt_empty_i,
	output logic       rd_o,
	output logic       trl_o,
	output logic [1:0] slot_o,
	output logic       clr_o,
	output logic       last_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_DATA,
		S_TRL
	} state_t;

	state_t           state_q;
	logic [SEQ_W-1:0] cnt_q;	// Sample index, then trailer slot
	logic             data_slot;
	logic             smp_done;
	logic             trl_done;

	assign data_slot = (state_q == S_DATA) && !evt_empty_i;	// Stall on empty sample FIFO
	assign smp_done  = (cnt_q == SEQ_W'(NUM_SAMPLES - 1));
	assign trl_done  = (cnt_q == SEQ_W'(TRL_SLOTS - 1));

	assign rd_o   = data_slot;
	assign clr_o  = data_slot && (cnt_q == '0);
	assign trl_o  = (state_q == S_TRL);
	assign slot_o = cnt_q[1:0];
	assign last_o = trl_o && trl_done;	// Also pops the L1A FIFO

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state_q <= S_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					cnt_q <= '0;
					if (!l1a_empty_i) begin
						state_q <= S_DATA;
					end
				end
				S_DATA: begin
					if (data_slot) begin
						if (smp_done) begin
							state_q <= S_TRL;
							cnt_q   <= '0;
						end else begin
							cnt_q <= cnt_q + 1'b1;
						end
					end
				end
				S_TRL: begin
					if (trl_done) begin
						state_q <= S_IDLE;	// At least one idle cycle per frame
						cnt_q   <= '0;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: begin
					state_q <= S_IDLE;
					cnt_q   <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- lane_voter.sv
`timescale 1ns/1ns
`default_nettype none

module lane_voter import chanlink_pkg::*; (
	input  wire         RCLK,
	input  wire         RST_RESYNC,
	input  wire [WORD_W-1:0] word_a_i,
	input  wire [WORD_W-1:0] word_b_i,
	input  wire [WORD_W-1:0] word_c_i,
	input  wire         valid_a_i,
	input  wire         valid_b_i,
	input  wire         valid_c_i,
	input  wire         last_a_i,
	input  wire         last_b_i,
	input  wire         last_c_i,
	input  wire         mlt_a_i,
	input  wire         mlt_b_i,
	input  wire         mlt_c_i,
	output frame_word_t dout_o,
	output logic        dvalid_o,
	output logic        last_wrd_o,
	output logic        mlt_ovlp_o
);

	localparam int VW = WORD_W + 3;

	logic [VW-1:0] lane_a;
	logic [VW-1:0] lane_b;
	logic [VW-1:0] lane_c;
	logic [VW-1:0] vote;

	assign lane_a = {word_a_i, valid_a_i, last_a_i, mlt_a_i};
	assign lane_b = {word_b_i, valid_b_i, last_b_i, mlt_b_i};
	assign lane_c = {word_c_i, valid_c_i, last_c_i, mlt_c_i};
	assign vote   = (lane_a & lane_b) | (lane_b & lane_c) | (lane_a & lane_c);	// 2 of 3

	always_ff @(posedge RCLK) begin
		dout_o <= vote[VW-1:3];
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid_o   <= 1'b0;
			last_wrd_o <= 1'b0;
			mlt_ovlp_o <= 1'b0;
		end else begin
			dvalid_o   <= vote[2];
			last_wrd_o <= vote[1];
			mlt_ovlp_o <= vote[0];
		end
	end

endmodule

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo import chanlink_pkg::*; #(
	parameter type payload_t = logic,
	parameter int FIFO_DEPTH = 16
)(
	input  wire              RCLK,
	input  wire              RST_RESYNC,
	input  wire              wr_i,
	input  wire payload_t    wr_data_i,
	input  wire              rd_i,
	output payload_t         rd_data_o,
	output logic             empty_o,
	output logic             full_o,
	output logic [OCC_W-1:0] count_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	payload_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [OCC_W-1:0] count_q;
	logic             wr_en;
	logic             rd_en;

	assign empty_o   = (count_q == '0);
	assign full_o    = (count_q == OCC_W'(FIFO_DEPTH));
	assign count_o   = count_q;
	assign wr_en     = wr_i && !full_o;	// Drop writes when full
	assign rd_en     = rd_i && !empty_o;
	assign rd_data_o = mem[rd_ptr_q];	// Show-ahead head

	always_ff @(posedge RCLK) begin
		if (wr_en) begin
			mem[wr_ptr_q] <= wr_data_i;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (rd_en) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			if (wr_en && !rd_en) begin
				count_q <= count_q + 1'b1;
			end else if (rd_en && !wr_en) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb.f
chanlink_pkg.sv
sync_fifo.sv
frame_sequencer.sv
frame_lane.sv
lane_voter.sv
chanlink_readout.sv
tb_chanlink_readout.sv

//--- tb_chanlink_readout.sv
`timescale 1ns/1ns
`default_nettype none

module tb_chanlink_readout import chanlink_pkg::*; ();

	localparam int NS  = 16;
	localparam int TMO = 300;	// Cycles per wait

	logic        RCLK = 1'b0;
	logic        RST_RESYNC = 1'b1;
	logic        evt_wr_i = 1'b0;
	evt_word_t   evt_i = '0;
	logic        l1a_wr_i = 1'b0;
	l1a_rec_t    l1a_i = '0;
	logic        warn_i = 1'b0;
	frame_word_t dout_o;
	logic        dvalid_o;
	logic        last_wrd_o;
	logic        mlt_ovlp_o;

	int          cyc = 0;
	int          val_errs = 0;
	int          tmo_errs = 0;
	logic [17:0] exp_q[$];	// {last, mlt, word}
	logic [17:0] got_q[$];
	int          got_cyc[$];
	int          wr_cyc[$];
	evt_word_t   smp_q[$];	// Written, not yet modelled

	chanlink_readout #(.NUM_SAMPLES(NS), .FIFO_DEPTH(16)) u_dut (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.evt_wr_i(evt_wr_i), .evt_i(evt_i), .l1a_wr_i(l1a_wr_i), .l1a_i(l1a_i),
		.warn_i(warn_i), .dout_o(dout_o), .dvalid_o(dvalid_o),
		.last_wrd_o(last_wrd_o), .mlt_ovlp_o(mlt_ovlp_o)
	);

	always #4 RCLK = ~RCLK;

	always @(posedge RCLK) begin
		cyc <= cyc + 1;
	end

	// Output monitor, sampled mid-cycle
	always @(negedge RCLK) begin
		if (dvalid_o) begin
			got_q.push_back({last_wrd_o, mlt_ovlp_o, dout_o});
			got_cyc.push_back(cyc);
		end
	end

	task automatic check_val(input logic [31:0] exp, input logic [31:0] act, input string what);
		if (exp !== act) begin
			val_errs++;
			$display("ERR %0t ns: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	task automatic step(input int n);
		repeat (n) begin
			@(posedge RCLK);
			#1;
		end
	endtask

	task automatic write_sample();
		logic [13:0] r;
		r = $urandom;
		evt_wr_i = 1'b1;
		evt_i    = r;
		wr_cyc.push_back(cyc);
		smp_q.push_back(evt_word_t'(r));
		step(1);
		evt_wr_i = 1'b0;
	endtask

	task automatic write_l1a(input logic [L1A_W-1:0] num);
		l1a_wr_i = 1'b1;
		l1a_i    = num;
		step(1);
		l1a_wr_i = 1'b0;
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////
	task automatic model_frame(input logic [L1A_W-1:0] num, input int occ, input logic warn);
		logic [CRC_W-1:0] crc;
		evt_word_t        s;
		crc = '0;	// Restarts every frame
		for (int k = 0; k < NS; k++) begin
			s = smp_q.pop_front();
			if (k != 0) begin
				crc = crc15_d13({1'b0, s.smp}, crc);	// First slot only clears
			end
			exp_q.push_back({1'b0, s.mlt_ovlp, 1'b0, ~s.ovlp, 2'b00, s.smp});
		end
		exp_q.push_back({3'b000, crc});
		exp_q.push_back({2'b00, TRL_MARKER});
		exp_q.push_back({2'b00, TRL_TAG, num[5:0], 5'(occ), warn});
		exp_q.push_back({2'b10, TRL_FILL});
	endtask

	task automatic wait_words(input int n);
		int t;
		t = 0;
		while (got_q.size() < n && t < TMO) begin
			step(1);
			t++;
		end
		if (got_q.size() < n) begin
			tmo_errs++;
			$display("Timeout: only %0d of %0d output words arrived", got_q.size(), n);
		end
	endtask

	task automatic compare_frames();
		int n;
		n = exp_q.size();
		wait_words(n);
		step(4);	// Catch stray words
		check_val(n, got_q.size(), "output word count");
		for (int i = 0; i < n && i < got_q.size(); i++) begin
			check_val(exp_q[i][15:0], got_q[i][15:0], $sformatf("word %0d", i));
			check_val(exp_q[i][16], got_q[i][16], $sformatf("mlt_ovlp_o at word %0d", i));
			check_val(exp_q[i][17], got_q[i][17], $sformatf("last_wrd_o at word %0d", i));
		end
		exp_q.delete();
		got_q.delete();
		got_cyc.delete();
		wr_cyc.delete();
	endtask

	////////////////////////////////
	// Directed tests
	////////////////////////////////
	task automatic test_idle();
		repeat (20) begin
			step(1);
			check_val(3'b000, {dvalid_o, last_wrd_o, mlt_ovlp_o}, "outputs while idle");
		end
	endtask

	task automatic test_single();
		logic [L1A_W-1:0] num;
		num = $urandom;
		repeat (NS) write_sample();
		write_l1a(num);
		model_frame(num, 1, 1'b0);
		compare_frames();
	endtask

	task automatic test_queued();
		logic [L1A_W-1:0] num [3];
		for (int k = 0; k < 3; k++) begin
			num[k] = $urandom;
			write_l1a(num[k]);
		end
		repeat (3 * NS) write_sample();
		for (int k = 0; k < 3; k++) begin
			model_frame(num[k], 3 - k, 1'b0);	// Pop happens after slot 2
		end
		compare_frames();
	endtask

	task automatic test_stall();
		logic [L1A_W-1:0] num;
		num = $urandom;
		write_l1a(num);
		step(3);
		repeat (NS) begin
			write_sample();
			step($urandom_range(0, 3));
		end
		model_frame(num, 1, 1'b0);
		wait_words(NS);
		// Sequencer waits on data, so each word trails its write by 3 cycles
		for (int i = 0; i < NS && i < got_cyc.size(); i++) begin
			check_val(3, got_cyc[i] - wr_cyc[i], $sformatf("latency of sample %0d", i));
		end
		compare_frames();
	endtask

	task automatic test_lane_fault();
		logic [L1A_W-1:0] num;
		num = $urandom;
		force u_dut.g_lane[1].u_lane.word_o = '1;
		repeat (NS) write_sample();
		write_l1a(num);
		model_frame(num, 1, 1'b0);
		compare_frames();
		release u_dut.g_lane[1].u_lane.word_o;
	endtask

	task automatic test_warn();
		logic [L1A_W-1:0] num;
		num = $urandom;
		repeat (NS) write_sample();
		warn_i = 1'b1;
		write_l1a(num);
		model_frame(num, 1, 1'b1);
		wait_words(NS + 4);
		warn_i = 1'b0;
		check_val(1, got_q[NS+2][0], "WARN bit in trailer word 2");
		compare_frames();
	endtask

	initial begin
		void'($urandom(32'hd2f7_4739));
		step(3);
		RST_RESYNC = 1'b0;
		step(2);
		test_idle();
		test_single();
		test_queued();
		test_stall();
		test_lane_fault();
		test_warn();
		$display("Summary: %0d value errors, %0d timeouts", val_errs, tmo_errs);
		if (val_errs == 0 && tmo_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
